// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the TCB probe testbench with Verilator.
# Run from anywhere; paths resolve against the project root.

set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --timescale 1ns/1ps \
  -f tcb_probe_top.f --top-module tcb_probe_tb -Mdir obj_dir > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$build_log"
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/Vtcb_probe_tb > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF -e '** FAIL **' "$sim_log"; then
  echo "result: failed"
  exit 1
fi

echo "result: passed"
exit 0

// File: tcb_probe_top.f
verilog/tcb_pkg.sv
verilog/tcb_if.sv
verilog/tcb_mem.sv
verilog/tcb_stat.sv
verilog/tcb_mon.sv
verilog/tcb_probe_top.sv
testbench/tb_clk.sv
testbench/tcb_probe_tb.sv

// File: testbench/tb_clk.sv
/*
  clock and reset for the TCB probe testbench
  20 ns clock period, reset low for the first 10 rising edges
  reset is released 1 ns after an edge, away from the sampling point
*/
`default_nettype none

module tb_clk (
  output logic bus,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 10;
  localparam int rst_cycles  = 10;

  // free running clock
  initial begin
    bus = 1'b0;
    forever #half_period bus = ~bus;
  end

  // reset held for rst_cycles edges
  initial begin
    arst_n = 1'b0;
    repeat (rst_cycles) @(posedge bus);
    #1;
    arst_n = 1'b1;
  end

endmodule : tb_clk

`default_nettype wire

// File: testbench/tcb_probe_tb.sv
/*
  testbench for tcb_probe_top with stimulus from testbench/tcb_probe_vectors.txt
  run from the project root so the vector path resolves
  inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
  op 3 lines draw a random gap and get their expected wait worked out here
  the expected wait total is the sum of all expected waits
*/
`default_nettype none

module tcb_probe_tb
  import tcb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int vec_max  = 64;
  localparam int vec_cols = 8;

  // one expected transfer and its handshake cycle
  typedef struct packed {
    tcb_log_t    rec;
    logic [31:0] hs_cyc;
    logic [15:0] idx;
  } exp_t;

  logic              bus;
  logic              arst_n;
  logic              vld;
  logic              wen;
  logic [tcb_aw-1:0] adr;
  logic [tcb_bw-1:0] ben;
  logic [tcb_dw-1:0] wdt;
  logic              rdy;
  logic [tcb_dw-1:0] rdt;
  logic              err;
  logic              log_vld;
  logic              log_wen;
  logic [tcb_aw-1:0] log_adr;
  logic [tcb_bw-1:0] log_ben;
  logic [tcb_dw-1:0] log_dat;
  logic              log_err;
  logic [cnt_w-1:0]  log_wait;
  logic [cnt_w-1:0]  cnt_rd;
  logic [cnt_w-1:0]  cnt_wr;
  logic [cnt_w-1:0]  cnt_err;
  logic [cnt_w-1:0]  cnt_wait;

  logic [31:0] vec_mem [vec_max*vec_cols];
  exp_t        resp_q [$];   // waiting for the response cycle
  exp_t        log_q  [$];   // waiting for the record
  int          cyc       = 0;
  int          cyc_limit = 100000;
  int          drv_errors;
  int          mon_errors;
  bit          running;

  tb_clk u_clk (
    .bus    (bus),
    .arst_n (arst_n)
  );

  tcb_probe_top uut (
    .bus (bus), .arst_n (arst_n),
    .vld (vld), .wen (wen), .adr (adr), .ben (ben), .wdt (wdt),
    .rdy (rdy), .rdt (rdt), .err (err),
    .log_vld (log_vld), .log_wen (log_wen), .log_adr (log_adr), .log_ben (log_ben),
    .log_dat (log_dat), .log_err (log_err), .log_wait (log_wait),
    .cnt_rd (cnt_rd), .cnt_wr (cnt_wr), .cnt_err (cnt_err), .cnt_wait (cnt_wait)
  );

  // prints a wrong value and returns 1
  function automatic int mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      return 1;
    end
    return 0;
  endfunction

  function automatic int reset_state_errors(input string when);
    int n;
    n = mismatch({when, " rdy"}, 32'(1'b1), 32'(rdy));
    n += mismatch({when, " log_vld"}, 32'(1'b0), 32'(log_vld));
    n += mismatch({when, " cnt_rd"}, 32'(0), 32'(cnt_rd));
    n += mismatch({when, " cnt_wr"}, 32'(0), 32'(cnt_wr));
    n += mismatch({when, " cnt_err"}, 32'(0), 32'(cnt_err));
    n += mismatch({when, " cnt_wait"}, 32'(0), 32'(cnt_wait));
    return n;
  endfunction

  ////////////////////////////////////////
  // cycle counter and timeout
  ////////////////////////////////////////

  initial begin
    while (cyc < cyc_limit) begin
      @(posedge bus);
      cyc++;
    end
    $display("timeout: run stopped after %0d cycles without finishing", cyc);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////
  // response and record checker
  ////////////////////////////////////////

  always @(negedge bus) begin
    exp_t e;
    if (running) begin
      // record due one cycle after the response cycle
      if (log_q.size() != 0 && log_q[0].hs_cyc + 1 == cyc) begin
        e = log_q.pop_front();
        if (log_vld !== 1'b1) begin
          mon_errors++;
          $display("transfer %0d gave no log record two cycles after its handshake", e.idx);
        end else begin
          mon_errors += mismatch($sformatf("t%0d log_wen", e.idx), 32'(e.rec.wen),
                                 32'(log_wen));
          mon_errors += mismatch($sformatf("t%0d log_adr", e.idx), 32'(e.rec.adr),
                                 32'(log_adr));
          mon_errors += mismatch($sformatf("t%0d log_ben", e.idx), 32'(e.rec.ben),
                                 32'(log_ben));
          mon_errors += mismatch($sformatf("t%0d log_dat", e.idx), e.rec.dat, log_dat);
          mon_errors += mismatch($sformatf("t%0d log_err", e.idx), 32'(e.rec.err),
                                 32'(log_err));
          mon_errors += mismatch($sformatf("t%0d log_wait", e.idx), 32'(e.rec.wait_cnt),
                                 32'(log_wait));
        end
      end else if (log_vld !== 1'b0) begin
        mon_errors++;
        $display("log_vld went high in cycle %0d with no record due", cyc);
      end
      // rdt is only compared for reads
      if (resp_q.size() != 0 && resp_q[0].hs_cyc == cyc) begin
        e = resp_q.pop_front();
        mon_errors += mismatch($sformatf("t%0d err", e.idx), 32'(e.rec.err), 32'(err));
        if (!e.rec.wen) begin
          mon_errors += mismatch($sformatf("t%0d rdt", e.idx), e.rec.dat, rdt);
        end
        log_q.push_back(e);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    int               n;
    int               base;
    int               op;
    int               gap;
    int               waited;
    bit               prev_wr;
    logic [cnt_w-1:0] exp_wait;
    logic [cnt_w-1:0] wait_sum;
    exp_t             e;
    void'($urandom(32'h5abf));
    vld        = 1'b0;
    wen        = 1'b0;
    adr        = '0;
    ben        = '0;
    wdt        = '0;
    drv_errors = 0;
    mon_errors = 0;
    running    = 1'b0;
    prev_wr    = 1'b0;
    wait_sum   = '0;

    $readmemh("testbench/tcb_probe_vectors.txt", vec_mem);
    // transfers end at the op f line
    n = 0;
    while (n < vec_max && vec_mem[n*vec_cols] != 32'hf) n++;
    cyc_limit = 40 * n + 100;

    repeat (3) begin
      @(negedge bus);
      drv_errors += reset_state_errors("in reset");
    end
    @(posedge arst_n);
    @(negedge bus);
    drv_errors += reset_state_errors("after reset");

    if (n == vec_max) begin
      drv_errors++;
      $display("vector file has no end line with op f");
    end else begin
      running = 1'b1;
      @(posedge bus);
      #1;
      for (int i = 0; i < n; i++) begin
        base = i * vec_cols;
        op   = vec_mem[base];
        gap  = (op == 3) ? int'($urandom % 3) : op;
        // one wait right behind a write with no gap
        if (op == 3) begin
          exp_wait = (prev_wr && gap == 0) ? cnt_w'(1) : '0;
        end else begin
          exp_wait = vec_mem[base+7][cnt_w-1:0];
        end
        if (gap > 0) begin
          vld = 1'b0;
          repeat (gap) @(posedge bus);
          #1;
        end
        vld = 1'b1;
        wen = vec_mem[base+1][0];
        adr = vec_mem[base+2][tcb_aw-1:0];
        ben = vec_mem[base+3][tcb_bw-1:0];
        wdt = vec_mem[base+4];
        // request held until rdy seen high
        waited = 0;
        @(negedge bus);
        while (rdy !== 1'b1) begin
          waited++;
          @(negedge bus);
        end
        @(posedge bus);
        #1;
        drv_errors += mismatch($sformatf("t%0d rdy stall cycles", i), 32'(exp_wait), waited);
        e.rec.wen      = wen;
        e.rec.adr      = adr;
        e.rec.ben      = ben;
        e.rec.dat      = wen ? wdt : vec_mem[base+5];
        e.rec.err      = vec_mem[base+6][0];
        e.rec.wait_cnt = exp_wait;
        e.hs_cyc       = cyc;
        e.idx          = 16'(i);
        resp_q.push_back(e);
        wait_sum += exp_wait;
        prev_wr  = wen;
      end
      vld = 1'b0;

      // drain both stages before the totals
      while (resp_q.size() != 0 || log_q.size() != 0) @(negedge bus);
      @(negedge bus);
      base = n * vec_cols;
      drv_errors += mismatch("total cnt_rd", vec_mem[base+1], 32'(cnt_rd));
      drv_errors += mismatch("total cnt_wr", vec_mem[base+2], 32'(cnt_wr));
      drv_errors += mismatch("total cnt_err", vec_mem[base+3], 32'(cnt_err));
      drv_errors += mismatch("total cnt_wait", 32'(wait_sum), 32'(cnt_wait));
    end

    $display("%0d transfers, errors: %0d stimulus side, %0d monitor side",
             n, drv_errors, mon_errors);
    if (drv_errors == 0 && mon_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tcb_probe_tb

`default_nettype wire

// File: testbench/tcb_probe_vectors.txt
// op wen adr ben wdt exp_rdt exp_err exp_wait (hex), op 0-2 idle gap, op 3 random gap 0-2
// last line: f cnt_rd cnt_wr cnt_err 0 0 0 0, exp_rdt is checked on reads only
1 1 000 f 11223344 00000000 0 0
0 1 004 f a5a5a5a5 00000000 0 1
0 0 000 f 00000000 11223344 0 1
0 0 004 f 00000000 a5a5a5a5 0 0
// partial writes merge into the old word
1 1 000 5 deadbeef 00000000 0 0
1 0 000 f 00000000 11ad33ef 0 0
0 1 004 a 01020304 00000000 0 0
0 0 004 f 00000000 01a503a5 0 1
// out of range, word 0 must survive
1 1 200 f ffffffff 00000000 1 0
0 0 200 f 00000000 00000000 1 1
0 0 3fc f 00000000 00000000 1 0
0 0 000 f 00000000 11ad33ef 0 0
2 1 1fc f 89abcdef 00000000 0 0
0 0 1fc f 00000000 89abcdef 0 1
// random gaps
3 1 008 f 00c0ffee 00000000 0 0
3 1 00c f 12345678 00000000 0 0
3 0 008 f 00000000 00c0ffee 0 0
3 0 00c f 00000000 12345678 0 0
// back to back, read ben is ignored
0 1 00c 3 aaaa5555 00000000 0 0
0 1 010 f 0badf00d 00000000 0 1
0 0 00c f 00000000 12345555 0 1
0 0 010 1 00000000 0badf00d 0 0
0 1 210 f 00000000 00000000 1 0
0 0 010 f 00000000 0badf00d 0 1
f d b 4 0 0 0 0

// File: verilog/tcb_if.sv
/*
  TCB signal bundle, no clock or reset inside
  the clock and reset travel next to it as plain ports
  handshake is vld and rdy high at a rising edge
  response (rdt, err) belongs to the cycle after the handshake
*/
`default_nettype none

interface tcb_if
  import tcb_pkg::*;
();

  // request phase, owned by the manager
  logic              vld;
  logic              wen;
  logic [tcb_aw-1:0] adr;
  logic [tcb_bw-1:0] ben;
  logic [tcb_dw-1:0] wdt;

  // back-pressure, independent of vld
  logic              rdy;

  // response phase, one cycle after the handshake
  logic [tcb_dw-1:0] rdt;
  logic              err;

  // manager side
  modport man (
    output vld, wen, adr, ben, wdt,
    input  rdy, rdt, err
  );

  // subordinate side
  modport sub (
    input  vld, wen, adr, ben, wdt,
    output rdy, rdt, err
  );

  // passive observer
  modport mon (
    input vld, wen, adr, ben, wdt,
    input rdy, rdt, err
  );

endinterface : tcb_if

`default_nettype wire

// File: verilog/tcb_mem.sv
/*
  single port memory subordinate on TCB
  reads ignore ben and return the whole word
  out of range: err=1, rdt=0, writes are dropped
  rdy drops for one cycle after every write handshake
  memory contents are not cleared by reset
*/
`default_nettype none

module tcb_mem
  import tcb_pkg::*;
(
  input  logic bus,
  input  logic arst_n,
  tcb_if.sub   tcb
);

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  logic              hs;       // handshake this cycle
  logic              oor;      // address beyond implemented words
  logic [mem_aw-1:0] idx;      // word index
  logic              wr_rec;   // write recovery flag

  logic [tcb_dw-1:0] mem [mem_words];

  logic [tcb_dw-1:0] rdt_q;
  logic              err_q;

  assign hs  = tcb.vld & tcb.rdy;
  // upper address bits above the word index must be zero
  assign oor = |tcb.adr[tcb_aw-1:mem_aw+tcb_ob];
  assign idx = tcb.adr[mem_aw+tcb_ob-1:tcb_ob];

  ////////////////////////////////////////
  // write recovery stall
  ////////////////////////////////////////

  // one idle cycle after each write handshake
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      wr_rec <= 1'b0;
    end else begin
      wr_rec <= hs & tcb.wen;
    end
  end

  assign tcb.rdy = ~wr_rec;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // byte lanes written only where ben is set
  always_ff @(posedge bus) begin
    if (hs && tcb.wen && !oor) begin
      for (int unsigned b = 0; b < tcb_bw; b++) begin
        if (tcb.ben[b]) begin
          mem[idx][8*b +: 8] <= tcb.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // err only lives in the response cycle
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= hs & oor;
    end
  end

  // read data, zero for an error
  always_ff @(posedge bus) begin
    if (hs) begin
      rdt_q <= oor ? '0 : mem[idx];
    end
  end

  assign tcb.rdt = rdt_q;
  assign tcb.err = err_q;

endmodule : tcb_mem

`default_nettype wire

// File: verilog/tcb_mon.sv
/*
  transfer monitor, builds one log record per completed transfer
  log_vld pulses two cycles after the handshake, fixed latency
  no back-pressure on the record output, the sink must take every pulse
  up to two transfers in flight, response stage and record stage
*/
`default_nettype none

module tcb_mon
  import tcb_pkg::*;
(
  input  logic             bus,
  input  logic             arst_n,
  tcb_if.mon               tcb,
  input  logic [cnt_w-1:0] wait_cnt,
  output logic             log_vld,
  output tcb_log_t         log_rec
);

  logic              hs;      // handshake
  logic              hs_d;    // response cycle of a transfer

  // request phase captured at the handshake
  logic              wen_d;
  logic [tcb_aw-1:0] adr_d;
  logic [tcb_bw-1:0] ben_d;
  logic [tcb_dw-1:0] wdt_d;

  tcb_log_t          rec;     // record under assembly

  assign hs = tcb.vld & tcb.rdy;

  ////////////////////////////////////////
  // request stage
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      hs_d <= 1'b0;
    end else begin
      hs_d <= hs;
    end
  end

  // held until the next handshake
  always_ff @(posedge bus) begin
    if (hs) begin
      wen_d <= tcb.wen;
      adr_d <= tcb.adr;
      ben_d <= tcb.ben;
      wdt_d <= tcb.wdt;
    end
  end

  ////////////////////////////////////////
  // record stage
  ////////////////////////////////////////

  // data by direction, read data is taken live from the response
  always_comb begin
    rec.wen      = wen_d;
    rec.adr      = adr_d;
    rec.ben      = ben_d;
    rec.dat      = wen_d ? wdt_d : tcb.rdt;
    rec.err      = tcb.err;
    rec.wait_cnt = wait_cnt;
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      log_vld <= 1'b0;
    end else begin
      log_vld <= hs_d;
    end
  end

  always_ff @(posedge bus) begin
    if (hs_d) begin
      log_rec <= rec;
    end
  end

endmodule : tcb_mon

`default_nettype wire

// File: verilog/tcb_pkg.sv
/*
  shared widths and the log record for the TCB probe subsystem
  byte addressed bus, one word per transfer, little endian byte lanes
  memory implements mem_words words starting at address 0
  anything above that is decoded as an error, there is no aliasing
  all statistics counters share cnt_w and wrap without saturation
*/
`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // byte address width
  localparam int unsigned tcb_aw = 10;
  // data width
  localparam int unsigned tcb_dw = 32;
  // one enable per byte lane
  localparam int unsigned tcb_bw = tcb_dw / 8;
  // address bits that select a byte inside a word
  localparam int unsigned tcb_ob = $clog2(tcb_bw);

  ////////////////////////////////////////
  // memory and counters
  ////////////////////////////////////////

  // implemented words, word address 0 to mem_words-1
  localparam int unsigned mem_words = 128;
  // word index width
  localparam int unsigned mem_aw = $clog2(mem_words);

  // statistics counters and per transfer wait count
  localparam int unsigned cnt_w = 16;

  ////////////////////////////////////////
  // log record
  ////////////////////////////////////////

  // one record per completed transfer
  typedef struct packed {
    logic              wen;       // 1 = write
    logic [tcb_aw-1:0] adr;       // byte address of the request
    logic [tcb_bw-1:0] ben;       // byte enables of the request
    logic [tcb_dw-1:0] dat;       // write data or read data
    logic              err;       // error from the subordinate
    logic [cnt_w-1:0]  wait_cnt;  // stall cycles before the handshake
  } tcb_log_t;

endpackage : tcb_pkg

`default_nettype wire

// File: verilog/tcb_probe_top.sv
/*
  top level of the TCB probe, plain ports only
  single manager outside, drives the request and obeys rdy
  request must stay stable while vld is high and rdy low
  log_ ports are valid only while log_vld is high
*/
`default_nettype none

module tcb_probe_top
  import tcb_pkg::*;
(
  input  logic              bus,
  input  logic              arst_n,
  // request
  input  logic              vld,
  input  logic              wen,
  input  logic [tcb_aw-1:0] adr,
  input  logic [tcb_bw-1:0] ben,
  input  logic [tcb_dw-1:0] wdt,
  // response
  output logic              rdy,
  output logic [tcb_dw-1:0] rdt,
  output logic              err,
  // log record
  output logic              log_vld,
  output logic              log_wen,
  output logic [tcb_aw-1:0] log_adr,
  output logic [tcb_bw-1:0] log_ben,
  output logic [tcb_dw-1:0] log_dat,
  output logic              log_err,
  output logic [cnt_w-1:0]  log_wait,
  // totals
  output logic [cnt_w-1:0]  cnt_rd,
  output logic [cnt_w-1:0]  cnt_wr,
  output logic [cnt_w-1:0]  cnt_err,
  output logic [cnt_w-1:0]  cnt_wait
);

  ////////////////////////////////////////
  // bus
  ////////////////////////////////////////

  tcb_if tcb ();

  logic [cnt_w-1:0] wait_cnt;  // stat to monitor
  tcb_log_t         log_rec;

  // request from the outside manager
  assign tcb.vld = vld;
  assign tcb.wen = wen;
  assign tcb.adr = adr;
  assign tcb.ben = ben;
  assign tcb.wdt = wdt;

  // response back out
  assign rdy = tcb.rdy;
  assign rdt = tcb.rdt;
  assign err = tcb.err;

  ////////////////////////////////////////
  // blocks
  ////////////////////////////////////////

  tcb_mem u_mem (
    .bus    (bus),
    .arst_n (arst_n),
    .tcb    (tcb.sub)
  );

  tcb_stat u_stat (
    .bus      (bus),
    .arst_n   (arst_n),
    .tcb      (tcb.mon),
    .wait_cnt (wait_cnt),
    .cnt_rd   (cnt_rd),
    .cnt_wr   (cnt_wr),
    .cnt_err  (cnt_err),
    .cnt_wait (cnt_wait)
  );

  tcb_mon u_mon (
    .bus      (bus),
    .arst_n   (arst_n),
    .tcb      (tcb.mon),
    .wait_cnt (wait_cnt),
    .log_vld  (log_vld),
    .log_rec  (log_rec)
  );

  // record fields out as plain ports
  assign log_wen  = log_rec.wen;
  assign log_adr  = log_rec.adr;
  assign log_ben  = log_rec.ben;
  assign log_dat  = log_rec.dat;
  assign log_err  = log_rec.err;
  assign log_wait = log_rec.wait_cnt;

endmodule : tcb_probe_top

`default_nettype wire

// File: verilog/tcb_stat.sv
/*
  transfer statistics, observes the bus only
  a wait cycle is a cycle with vld high and rdy low
  wait_cnt holds the wait of the last transfer, valid in its response cycle
  all totals wrap at 2**cnt_w
*/
`default_nettype none

module tcb_stat
  import tcb_pkg::*;
(
  input  logic             bus,
  input  logic             arst_n,
  tcb_if.mon               tcb,
  output logic [cnt_w-1:0] wait_cnt,
  output logic [cnt_w-1:0] cnt_rd,
  output logic [cnt_w-1:0] cnt_wr,
  output logic [cnt_w-1:0] cnt_err,
  output logic [cnt_w-1:0] cnt_wait
);

  logic             hs;        // handshake
  logic             stall;     // request waiting on rdy
  logic             hs_d;      // response cycle marker
  logic [cnt_w-1:0] wait_run;  // running wait of the open transfer

  assign hs    = tcb.vld & tcb.rdy;
  assign stall = tcb.vld & ~tcb.rdy;

  ////////////////////////////////////////
  // per transfer wait
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      wait_run <= '0;
      wait_cnt <= '0;
      hs_d     <= 1'b0;
    end else begin
      hs_d <= hs;
      if (hs) begin
        // hand over the count, start fresh for the next request
        wait_cnt <= wait_run;
        wait_run <= '0;
      end else if (stall) begin
        wait_run <= wait_run + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // running totals
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cnt_rd   <= '0;
      cnt_wr   <= '0;
      cnt_err  <= '0;
      cnt_wait <= '0;
    end else begin
      // direction split at the handshake
      if (hs && !tcb.wen) cnt_rd <= cnt_rd + 1'b1;
      if (hs &&  tcb.wen) cnt_wr <= cnt_wr + 1'b1;
      // err is sampled in the response cycle
      if (hs_d && tcb.err) cnt_err <= cnt_err + 1'b1;
      // every stalled cycle, across transfers
      if (stall) cnt_wait <= cnt_wait + 1'b1;
    end
  end

endmodule : tcb_stat

`default_nettype wire
